// File: Bender.yml
package:
  name: island

sources:
  - include_dirs:
      - .
    files:
      - island_bus_pkg.sv
      - island_ctrl_pkg.sv
      - island_mem_bank.sv
      - island_boot_rom.sv
      - island_soc_ctrl.sv
      - island_periph_demux.sv
      - island_bus_decoder.sv
      - island_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - island_tb_clk.sv
      - island_tb.sv

// File: island_boot_rom.sv
/*
 * Boot ROM
 * Serves the fixed boot image, writes are acknowledged and dropped
 */

`include "island_consts.svh"

module island_boot_rom (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stb_i,
  input  logic [`ISLAND_AW-1:0] adr_i,
  output logic [`ISLAND_DW-1:0] dat_o,
  output logic                  ack_o
);

  import island_ctrl_pkg::*;

  logic [9:0]            word_idx;
  logic [`ISLAND_DW-1:0] rom_word;
  logic [`ISLAND_DW-1:0] dat_q;
  logic                  ack_q;

  assign word_idx = adr_i[11:2];

  // Anything past the image reads as zero
  always_comb begin
    rom_word = '0;
    if (word_idx < `ISLAND_ROM_WORDS) begin
      rom_word = BOOT_ROM_IMAGE[word_idx[$clog2(`ISLAND_ROM_WORDS)-1:0]];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ack
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i && !ack_q;
    end
  end

  always_ff @(posedge clk_i) begin : proc_rdata
    if (stb_i && !ack_q) begin
      dat_q <= rom_word;
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;

endmodule

// File: island_bus_decoder.sv
/*
 * Top address decoder
 * Steers the Wishbone strobe to a bank or the peripheral region
 * and merges the responses
 */

`include "island_consts.svh"

module island_bus_decoder (
  input  logic                  wb_stb_i,
  input  logic                  wb_cyc_i,
  input  logic [`ISLAND_AW-1:0] wb_adr_i,

  output logic                  bank0_stb_o,
  output logic                  bank1_stb_o,
  output logic                  periph_stb_o,

  input  logic                  bank0_ack_i,
  input  logic                  bank1_ack_i,
  input  logic                  periph_ack_i,
  input  logic                  periph_err_i,

  input  logic [`ISLAND_DW-1:0] bank0_dat_i,
  input  logic [`ISLAND_DW-1:0] bank1_dat_i,
  input  logic [`ISLAND_DW-1:0] periph_dat_i,

  output logic [`ISLAND_DW-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o
);

  import island_bus_pkg::*;

  island_target_e target;
  logic           req;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  always_comb begin
    // Default covers the peripherals and every unmapped address
    target = TGT_PERIPH;
    if ((wb_adr_i - `ISLAND_BANK0_BASE) < `ISLAND_BANK_BYTES) begin
      target = TGT_BANK0;
    end else if ((wb_adr_i - `ISLAND_BANK1_BASE) < `ISLAND_BANK_BYTES) begin
      target = TGT_BANK1;
    end
  end

  assign req = wb_cyc_i && wb_stb_i;

  assign bank0_stb_o  = req && (target == TGT_BANK0);
  assign bank1_stb_o  = req && (target == TGT_BANK1);
  assign periph_stb_o = req && (target == TGT_PERIPH);

  // --------------------------------------------------
  // Response merge
  // --------------------------------------------------
  always_comb begin
    if (bank0_ack_i) begin
      wb_dat_o = bank0_dat_i;
    end else if (bank1_ack_i) begin
      wb_dat_o = bank1_dat_i;
    end else begin
      wb_dat_o = periph_dat_i;
    end
  end

  assign wb_ack_o = bank0_ack_i | bank1_ack_i | periph_ack_i;
  assign wb_err_o = periph_err_i;

endmodule

// File: island_bus_pkg.sv
/*
 * Safety island bus package
 * Target encodings used by the top decoder and the peripheral decoder
 */

package island_bus_pkg;

  // --------------------------------------------------
  // Top-level address decoder targets
  // --------------------------------------------------
  typedef enum logic [1:0] {
    TGT_BANK0  = 2'd0,
    TGT_BANK1  = 2'd1,
    TGT_PERIPH = 2'd2
  } island_target_e;

  // --------------------------------------------------
  // Peripheral region targets
  // --------------------------------------------------
  typedef enum logic [1:0] {
    PER_SOC_CTRL = 2'd0,
    PER_BOOT_ROM = 2'd1,
    PER_ERROR    = 2'd2
  } periph_target_e;

endpackage

// File: island_consts.svh
/*
 * Safety island constants
 * Bus widths, memory map, bank size and fixed response values
 */

`ifndef ISLAND_CONSTS_SVH
`define ISLAND_CONSTS_SVH

// Bus widths
`define ISLAND_AW   32
`define ISLAND_DW   32
`define ISLAND_SELW 4

// SRAM banks
`define ISLAND_BANK_BYTES 32'h0000_0400
`define ISLAND_BANK0_BASE 32'h0000_0000
`define ISLAND_BANK1_BASE 32'h0000_0400

// Peripheral region, each peripheral spans one range
`define ISLAND_PERIPH_BASE  32'h0020_0000
`define ISLAND_PERIPH_RANGE 32'h0000_1000
`define ISLAND_SOC_CTRL_OFS 32'h0000_0000
`define ISLAND_BOOT_ROM_OFS 32'h0000_1000

`define ISLAND_ROM_WORDS 8
`define ISLAND_ERR_DATA  32'hBADCAB1E

// Core starts just past the ROM vector area
`define ISLAND_BOOT_ADDR_RST (`ISLAND_PERIPH_BASE + `ISLAND_BOOT_ROM_OFS + 32'h0000_0080)

`endif

// File: island_ctrl_pkg.sv
/*
 * Safety island control package
 * Boot modes, SoC control register offsets and the boot ROM image
 */

`include "island_consts.svh"

package island_ctrl_pkg;

  typedef enum logic [1:0] {
    BOOT_JTAG    = 2'd0,
    BOOT_PRELOAD = 2'd1,
    BOOT_SPI     = 2'd2
  } bootmode_e;

  // Byte offsets inside the SoC control block
  typedef enum logic [3:0] {
    REG_FETCHEN  = 4'h0,
    REG_BOOTADDR = 4'h4,
    REG_BOOTMODE = 4'h8
  } soc_reg_e;

  // Boot stub: load the entry point from word 7 and jump there
  localparam logic [31:0] BOOT_ROM_IMAGE [`ISLAND_ROM_WORDS] = '{
    32'h0000_0297,  // auipc t0, 0
    32'h01c2_8293,  // addi  t0, t0, 0x1c
    32'h0002_a303,  // lw    t1, 0(t0)
    32'h0003_0067,  // jr    t1
    32'h1050_0073,  // wfi
    32'h0000_006f,  // j     .
    32'h0000_0013,  // nop
    32'h0000_0000   // entry point, start of bank 0
  };

endpackage

// File: island_mem_bank.sv
/*
 * SRAM bank
 * Word-addressed memory with byte enables and a one-cycle registered ack
 */

`include "island_consts.svh"

module island_mem_bank (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     stb_i,
  input  logic                     we_i,
  input  logic [`ISLAND_SELW-1:0]  sel_i,
  input  logic [`ISLAND_AW-1:0]    adr_i,
  input  logic [`ISLAND_DW-1:0]    dat_i,
  output logic [`ISLAND_DW-1:0]    dat_o,
  output logic                     ack_o
);

  localparam int unsigned bank_words = `ISLAND_BANK_BYTES / 4;
  localparam int unsigned idx_msb    = $clog2(`ISLAND_BANK_BYTES) - 1;

  logic [`ISLAND_DW-1:0] mem_q [bank_words];
  logic [`ISLAND_DW-1:0] dat_q;
  logic                  ack_q;
  logic                  access;
  logic [idx_msb-2:0]    word_idx;

  // New access only while no ack is pending
  assign access   = stb_i && !ack_q;
  // Upper bits select the bank and are ignored here
  assign word_idx = adr_i[idx_msb:2];

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ack
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin : proc_mem
    if (access && we_i) begin
      for (int i = 0; i < `ISLAND_SELW; i++) begin
        if (sel_i[i]) begin
          mem_q[word_idx][8*i +: 8] <= dat_i[8*i +: 8];
        end
      end
    end else if (access) begin
      dat_q <= mem_q[word_idx];
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;

endmodule

// File: island_periph_demux.sv
/*
 * Peripheral region decoder
 * Routes to SoC control or boot ROM, everything else hits the error responder
 */

`include "island_consts.svh"

module island_periph_demux (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [`ISLAND_SELW-1:0]    sel_i,
  input  logic [`ISLAND_AW-1:0]      adr_i,
  input  logic [`ISLAND_DW-1:0]      dat_i,
  output logic [`ISLAND_DW-1:0]      dat_o,
  output logic                       ack_o,
  output logic                       err_o,
  input  island_ctrl_pkg::bootmode_e bootmode_i,
  input  logic                       fetch_enable_selector_i,
  input  logic                       fetch_enable_i,
  output logic                       fetch_enable_o,
  output logic [`ISLAND_AW-1:0]      boot_addr_o
);

  import island_bus_pkg::*;

  periph_target_e        per_sel;
  logic                  soc_stb, rom_stb, err_stb;
  logic                  soc_ack, rom_ack;
  logic [`ISLAND_DW-1:0] soc_dat, rom_dat;
  logic                  err_q;

  // Full address compare, the region below the periph base lands here too
  always_comb begin
    per_sel = PER_ERROR;
    if ((adr_i - (`ISLAND_PERIPH_BASE + `ISLAND_SOC_CTRL_OFS)) < `ISLAND_PERIPH_RANGE) begin
      per_sel = PER_SOC_CTRL;
    end else if ((adr_i - (`ISLAND_PERIPH_BASE + `ISLAND_BOOT_ROM_OFS)) <
                 `ISLAND_PERIPH_RANGE) begin
      per_sel = PER_BOOT_ROM;
    end
  end

  assign soc_stb = stb_i && (per_sel == PER_SOC_CTRL);
  assign rom_stb = stb_i && (per_sel == PER_BOOT_ROM);
  assign err_stb = stb_i && (per_sel == PER_ERROR);

  island_soc_ctrl i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .stb_i                   ( soc_stb ),
    .we_i,
    .sel_i,
    .adr_i,
    .dat_i,
    .dat_o                   ( soc_dat ),
    .ack_o                   ( soc_ack ),
    .bootmode_i,
    .fetch_enable_selector_i,
    .fetch_enable_i,
    .fetch_enable_o,
    .boot_addr_o
  );

  island_boot_rom i_boot_rom (
    .clk_i,
    .rst_ni,
    .stb_i ( rom_stb ),
    .adr_i,
    .dat_o ( rom_dat ),
    .ack_o ( rom_ack )
  );

  // Error responder, one err pulse per request
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_err
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_stb && !err_q;
    end
  end

  always_comb begin
    if (soc_ack) begin
      dat_o = soc_dat;
    end else if (rom_ack) begin
      dat_o = rom_dat;
    end else begin
      dat_o = `ISLAND_ERR_DATA;
    end
  end

  assign ack_o = soc_ack | rom_ack;
  assign err_o = err_q;

endmodule

// File: island_soc_ctrl.sv
/*
 * SoC control registers
 * Fetch enable with hardware override, boot address and boot mode status
 */

`include "island_consts.svh"

module island_soc_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [`ISLAND_SELW-1:0]    sel_i,
  input  logic [`ISLAND_AW-1:0]      adr_i,
  input  logic [`ISLAND_DW-1:0]      dat_i,
  output logic [`ISLAND_DW-1:0]      dat_o,
  output logic                       ack_o,
  input  island_ctrl_pkg::bootmode_e bootmode_i,
  input  logic                       fetch_enable_selector_i,
  input  logic                       fetch_enable_i,
  output logic                       fetch_enable_o,
  output logic [`ISLAND_AW-1:0]      boot_addr_o
);

  import island_ctrl_pkg::*;

  logic                  access;
  logic                  reg_hit;
  soc_reg_e              reg_ofs;
  logic                  fetchen_q;
  logic [`ISLAND_AW-1:0] boot_addr_q;
  logic [`ISLAND_DW-1:0] rdata;
  logic [`ISLAND_DW-1:0] dat_q;
  logic                  ack_q;

  assign access  = stb_i && !ack_q;
  // Registers live in the first 16 bytes of the block
  assign reg_hit = (adr_i[11:4] == '0);
  assign reg_ofs = soc_reg_e'(adr_i[3:0]);

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    rdata = '0;
    if (reg_hit) begin
      case (reg_ofs)
        REG_FETCHEN:  rdata = {{(`ISLAND_DW-1){1'b0}}, fetchen_q};
        REG_BOOTADDR: rdata = boot_addr_q;
        REG_BOOTMODE: rdata = {{(`ISLAND_DW-2){1'b0}}, bootmode_i};
        default:      rdata = '0;
      endcase
    end
  end

  // --------------------------------------------------
  // Writable registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_regs
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      fetchen_q   <= 1'b0;
      boot_addr_q <= `ISLAND_BOOT_ADDR_RST;
    end else begin
      ack_q <= access;
      if (access && we_i && reg_hit) begin
        if (reg_ofs == REG_FETCHEN && sel_i[0]) begin
          fetchen_q <= dat_i[0];
        end
        if (reg_ofs == REG_BOOTADDR) begin
          for (int i = 0; i < `ISLAND_SELW; i++) begin
            if (sel_i[i]) begin
              boot_addr_q[8*i +: 8] <= dat_i[8*i +: 8];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_rdata
    if (access && !we_i) begin
      dat_q <= rdata;
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;

  // Hardware selector takes over the fetch enable
  assign fetch_enable_o = fetch_enable_selector_i ? fetch_enable_i : fetchen_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

// File: island_tb.sv
/*
 * Safety island testbench
 * Wishbone stimulus, reference model of the memory map and response checks
 */

`include "island_consts.svh"

module island_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import island_bus_pkg::*;
  import island_ctrl_pkg::*;

  localparam int unsigned wait_limit = 20;
  localparam int unsigned bank_words = `ISLAND_BANK_BYTES / 4;

  logic                    clk, rst_n;
  logic                    wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  logic [`ISLAND_SELW-1:0] wb_sel;
  logic [`ISLAND_AW-1:0]   wb_adr, boot_addr;
  logic [`ISLAND_DW-1:0]   wb_wdata, wb_rdata;
  bootmode_e               bootmode;
  logic                    fe_sel, fe_in, fe_out;

  // Reference model state
  logic [31:0] bank0_model [bank_words];
  logic [31:0] bank1_model [bank_words];
  logic        fetchen_model;
  logic [31:0] boot_addr_model;

  // Responses waiting for the compare process
  logic [31:0] adr_q [$];
  logic [32:0] exp_q [$];
  logic [31:0] dat_q [$];
  logic        read_q [$];
  logic        ack_q [$];
  logic        err_q [$];
  int unsigned lat_q [$];

  int unsigned check_count, fail_count, test_count, test_fail_count, test_base;
  string       test_name;
  int unsigned idx_list [12];
  logic [31:0] word;

  island_tb_clk i_clk (.clk_o(clk), .rst_no(rst_n));

  island_top DUT (
    .clk_i(clk), .rst_ni(rst_n),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_sel_i(wb_sel),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_wdata), .wb_dat_o(wb_rdata),
    .wb_ack_o(wb_ack), .wb_err_o(wb_err),
    .bootmode_i(bootmode), .fetch_enable_selector_i(fe_sel),
    .fetch_enable_i(fe_in), .fetch_enable_o(fe_out), .boot_addr_o(boot_addr)
  );

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      fail_count++;
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    check_count++;
    assert (cond) else begin
      fail_count++;
      $display("%s", what);
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic bit in_window(input logic [31:0] adr, input logic [31:0] base,
                                   input logic [31:0] size);
    return (adr >= base) && ((adr - base) < size);
  endfunction

  function automatic island_target_e top_target(input logic [31:0] adr);
    if (in_window(adr, `ISLAND_BANK0_BASE, `ISLAND_BANK_BYTES)) return TGT_BANK0;
    if (in_window(adr, `ISLAND_BANK1_BASE, `ISLAND_BANK_BYTES)) return TGT_BANK1;
    return TGT_PERIPH;
  endfunction

  function automatic periph_target_e periph_target(input logic [31:0] adr);
    if (in_window(adr, `ISLAND_PERIPH_BASE + `ISLAND_SOC_CTRL_OFS, `ISLAND_PERIPH_RANGE)) begin
      return PER_SOC_CTRL;
    end
    if (in_window(adr, `ISLAND_PERIPH_BASE + `ISLAND_BOOT_ROM_OFS, `ISLAND_PERIPH_RANGE)) begin
      return PER_BOOT_ROM;
    end
    return PER_ERROR;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] dat,
                                              input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = dat[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Expected response as {err, read data}
  function automatic logic [32:0] predict(input logic [31:0] adr);
    int unsigned idx;
    idx = adr[9:2];
    case (top_target(adr))
      TGT_BANK0: return {1'b0, bank0_model[idx]};
      TGT_BANK1: return {1'b0, bank1_model[idx]};
      default: ;
    endcase
    case (periph_target(adr))
      PER_SOC_CTRL: begin
        if (adr[11:0] == 12'(REG_FETCHEN)) return {1'b0, 31'd0, fetchen_model};
        if (adr[11:0] == 12'(REG_BOOTADDR)) return {1'b0, boot_addr_model};
        if (adr[11:0] == 12'(REG_BOOTMODE)) return {1'b0, 30'd0, bootmode};
        return 33'd0;
      end
      PER_BOOT_ROM: begin
        idx = adr[11:2];
        if (idx < `ISLAND_ROM_WORDS) return {1'b0, BOOT_ROM_IMAGE[idx]};
        return 33'd0;
      end
      default: return {1'b1, `ISLAND_ERR_DATA};
    endcase
  endfunction

  task automatic model_write(input logic [31:0] adr, input logic [3:0] sel,
                             input logic [31:0] dat);
    int unsigned idx;
    idx = adr[9:2];
    if (top_target(adr) == TGT_BANK0) begin
      bank0_model[idx] = merge_bytes(bank0_model[idx], dat, sel);
    end else if (top_target(adr) == TGT_BANK1) begin
      bank1_model[idx] = merge_bytes(bank1_model[idx], dat, sel);
    end else if (periph_target(adr) == PER_SOC_CTRL) begin
      if (adr[11:0] == 12'(REG_FETCHEN) && sel[0]) fetchen_model = dat[0];
      if (adr[11:0] == 12'(REG_BOOTADDR)) begin
        boot_addr_model = merge_bytes(boot_addr_model, dat, sel);
      end
    end
  endtask

  // --------------------------------------------------
  // Wishbone master
  // --------------------------------------------------
  task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                            input logic [31:0] dat);
    int unsigned cycles;
    bit          done;
    exp_q.push_back(predict(adr));
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_sel   = sel;
    wb_adr   = adr;
    wb_wdata = dat;
    cycles   = 0;
    done     = 1'b0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (wb_ack || wb_err) begin
        done = 1'b1;
      end else if (cycles >= wait_limit) begin
        abort_run($sformatf("Timeout: address 0x%08h got no ack or err within %0d cycles",
                            adr, wait_limit));
      end
    end
    adr_q.push_back(adr);
    dat_q.push_back(wb_rdata);
    read_q.push_back(!we);
    ack_q.push_back(wb_ack);
    err_q.push_back(wb_err);
    lat_q.push_back(cycles);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (we) model_write(adr, sel, dat);
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] dat);
    bus_access(1'b1, sel, adr, dat);
  endtask

  task automatic bus_read(input logic [31:0] adr);
    bus_access(1'b0, 4'hF, adr, 32'd0);
  endtask

  // Responses captured on the falling edge are compared on the next rising edge
  always @(posedge clk) begin : compare_responses
    logic [31:0] adr;
    logic [32:0] exp;
    while (adr_q.size() > 0) begin
      adr = adr_q.pop_front();
      exp = exp_q.pop_front();
      check_value("wb_err_o", 32'(err_q.pop_front()), 32'(exp[32]));
      check_value("wb_ack_o", 32'(ack_q.pop_front()), 32'(!exp[32]));
      if (read_q.pop_front()) begin
        check_value($sformatf("wb_dat_o at 0x%08h", adr), dat_q.pop_front(), exp[31:0]);
      end else begin
        void'(dat_q.pop_front());
      end
      check_true(lat_q[0] == 1, $sformatf("Access at 0x%08h took %0d cycles instead of one",
                                          adr, lat_q[0]));
      void'(lat_q.pop_front());
    end
  end

  task automatic start_test(input string name);
    test_count++;
    test_name = name;
    test_base = fail_count;
  endtask

  task automatic finish_test();
    @(negedge clk);
    if (fail_count == test_base) begin
      $display("Test %0d (%s): ok", test_count, test_name);
    end else begin
      test_fail_count++;
      $display("Test %0d (%s): %0d errors", test_count, test_name, fail_count - test_base);
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : run_tests
    int unsigned cycles;
    logic [3:0]  sel_list [9];
    void'($urandom(62959));
    {wb_cyc, wb_stb, wb_we} = 3'b000;
    wb_sel          = '0;
    wb_adr          = '0;
    wb_wdata        = '0;
    bootmode        = BOOT_JTAG;
    fe_sel          = 1'b0;
    fe_in           = 1'b1;
    fetchen_model   = 1'b0;
    boot_addr_model = `ISLAND_BOOT_ADDR_RST;
    sel_list        = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'h5, 4'hA, 4'h0};
    cycles          = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles >= wait_limit) abort_run("Reset was never released");
    end
    @(negedge clk);

    start_test("reset values");
    check_value("wb_ack_o", 32'(wb_ack), 32'd0);
    check_value("wb_err_o", 32'(wb_err), 32'd0);
    check_value("boot_addr_o", boot_addr, `ISLAND_BOOT_ADDR_RST);
    check_value("fetch_enable_o", 32'(fe_out), 32'd0);
    fe_sel = 1'b1;
    fe_in  = 1'b1;
    @(negedge clk);
    check_value("fetch_enable_o", 32'(fe_out), 32'd1);
    fe_in = 1'b0;
    @(negedge clk);
    check_value("fetch_enable_o", 32'(fe_out), 32'd0);
    fe_sel = 1'b0;
    finish_test();

    start_test("bank write and read");
    foreach (idx_list[i]) begin
      idx_list[i] = $urandom_range(0, bank_words - 1);
      bus_write(`ISLAND_BANK0_BASE + 4 * idx_list[i], 4'hF, $urandom());
      bus_write(`ISLAND_BANK1_BASE + 4 * idx_list[i], 4'hF, $urandom());
    end
    foreach (idx_list[i]) begin
      bus_read(`ISLAND_BANK0_BASE + 4 * idx_list[i]);
      bus_read(`ISLAND_BANK1_BASE + 4 * idx_list[i]);
    end
    finish_test();

    start_test("byte select merge");
    for (int w = 0; w < 2; w++) begin
      word = (w == 0) ? `ISLAND_BANK0_BASE + 32'h3c : `ISLAND_BANK1_BASE + 32'h3fc;
      bus_write(word, 4'hF, $urandom());
      foreach (sel_list[i]) begin
        bus_write(word, sel_list[i], $urandom());
        bus_read(word);
      end
    end
    finish_test();

    start_test("boot ROM");
    for (int i = 0; i < 10; i++) begin
      bus_read(`ISLAND_PERIPH_BASE + `ISLAND_BOOT_ROM_OFS + 4 * i);
    end
    bus_read(`ISLAND_PERIPH_BASE + `ISLAND_BOOT_ROM_OFS + 32'hffc);
    bus_write(`ISLAND_PERIPH_BASE + `ISLAND_BOOT_ROM_OFS + 32'h8, 4'hF, $urandom());
    bus_read(`ISLAND_PERIPH_BASE + `ISLAND_BOOT_ROM_OFS + 32'h8);
    finish_test();

    start_test("SoC control");
    word = `ISLAND_PERIPH_BASE + `ISLAND_SOC_CTRL_OFS;
    bus_write(word + REG_FETCHEN, 4'hF, 32'd1);
    check_value("fetch_enable_o", 32'(fe_out), 32'(fetchen_model));
    bus_read(word + REG_FETCHEN);
    bus_write(word + REG_FETCHEN, 4'hF, 32'hFFFF_FFFE);
    check_value("fetch_enable_o", 32'(fe_out), 32'(fetchen_model));
    bus_write(word + REG_BOOTADDR, 4'hF, $urandom());
    check_value("boot_addr_o", boot_addr, boot_addr_model);
    bus_write(word + REG_BOOTADDR, 4'h2, $urandom());
    check_value("boot_addr_o", boot_addr, boot_addr_model);
    bus_read(word + REG_BOOTADDR);
    bootmode = BOOT_PRELOAD;
    bus_read(word + REG_BOOTMODE);
    bootmode = BOOT_SPI;
    bus_write(word + REG_BOOTMODE, 4'hF, 32'hFFFF_FFFF);
    check_value("fetch_enable_o", 32'(fe_out), 32'(fetchen_model));
    check_value("boot_addr_o", boot_addr, boot_addr_model);
    bus_read(word + REG_BOOTMODE);
    bus_read(word + 32'hc);
    bus_read(word + 32'h14);
    finish_test();

    start_test("error responder");
    foreach (idx_list[i]) begin
      case (i % 6)
        0: word = 32'h0000_0800;
        1: word = 32'h1000_0000;
        2: word = `ISLAND_PERIPH_BASE + 32'h2000;
        3: word = `ISLAND_PERIPH_BASE + 32'h5ffc;
        4: word = `ISLAND_PERIPH_BASE - 32'h4;
        default: word = 32'hFFFF_FFFC;
      endcase
      bus_write(word, 4'hF, $urandom());
      bus_read(word);
    end
    finish_test();

    $display("%0d tests, %0d failed; %0d checks, %0d errors",
             test_count, test_fail_count, check_count, fail_count);
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: island_tb_clk.sv
/*
 * Testbench clock and reset
 * 100 ns clock, active-low reset held for two cycles
 */

module island_tb_clk (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Release between edges so no flop sees it change
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: island_top.f
+incdir+.
island_bus_pkg.sv
island_ctrl_pkg.sv
island_mem_bank.sv
island_boot_rom.sv
island_soc_ctrl.sv
island_periph_demux.sv
island_bus_decoder.sv
island_top.sv
island_tb_clk.sv
island_tb.sv

// File: island_top.sv
/*
 * Safety island memory and control subsystem
 * Wishbone classic slave in front of two SRAM banks and the peripheral region
 */

`include "island_consts.svh"

module island_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Wishbone slave port
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`ISLAND_SELW-1:0]    wb_sel_i,
  input  logic [`ISLAND_AW-1:0]      wb_adr_i,
  input  logic [`ISLAND_DW-1:0]      wb_dat_i,
  output logic [`ISLAND_DW-1:0]      wb_dat_o,
  output logic                       wb_ack_o,
  output logic                       wb_err_o,

  // Boot and fetch control
  input  island_ctrl_pkg::bootmode_e bootmode_i,
  input  logic                       fetch_enable_selector_i,
  input  logic                       fetch_enable_i,
  output logic                       fetch_enable_o,
  output logic [`ISLAND_AW-1:0]      boot_addr_o
);

  logic                  bank0_stb, bank1_stb, periph_stb;
  logic                  bank0_ack, bank1_ack, periph_ack, periph_err;
  logic [`ISLAND_DW-1:0] bank0_dat, bank1_dat, periph_dat;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  island_bus_decoder i_bus_decoder (
    .wb_stb_i,
    .wb_cyc_i,
    .wb_adr_i,
    .bank0_stb_o  ( bank0_stb  ),
    .bank1_stb_o  ( bank1_stb  ),
    .periph_stb_o ( periph_stb ),
    .bank0_ack_i  ( bank0_ack  ),
    .bank1_ack_i  ( bank1_ack  ),
    .periph_ack_i ( periph_ack ),
    .periph_err_i ( periph_err ),
    .bank0_dat_i  ( bank0_dat  ),
    .bank1_dat_i  ( bank1_dat  ),
    .periph_dat_i ( periph_dat ),
    .wb_dat_o,
    .wb_ack_o,
    .wb_err_o
  );

  // --------------------------------------------------
  // Memories
  // --------------------------------------------------
  island_mem_bank i_bank0 (
    .clk_i,
    .rst_ni,
    .stb_i ( bank0_stb ),
    .we_i  ( wb_we_i   ),
    .sel_i ( wb_sel_i  ),
    .adr_i ( wb_adr_i  ),
    .dat_i ( wb_dat_i  ),
    .dat_o ( bank0_dat ),
    .ack_o ( bank0_ack )
  );

  island_mem_bank i_bank1 (
    .clk_i,
    .rst_ni,
    .stb_i ( bank1_stb ),
    .we_i  ( wb_we_i   ),
    .sel_i ( wb_sel_i  ),
    .adr_i ( wb_adr_i  ),
    .dat_i ( wb_dat_i  ),
    .dat_o ( bank1_dat ),
    .ack_o ( bank1_ack )
  );

  // --------------------------------------------------
  // Peripherals
  // --------------------------------------------------
  island_periph_demux i_periph (
    .clk_i,
    .rst_ni,
    .stb_i                   ( periph_stb ),
    .we_i                    ( wb_we_i    ),
    .sel_i                   ( wb_sel_i   ),
    .adr_i                   ( wb_adr_i   ),
    .dat_i                   ( wb_dat_i   ),
    .dat_o                   ( periph_dat ),
    .ack_o                   ( periph_ack ),
    .err_o                   ( periph_err ),
    .bootmode_i,
    .fetch_enable_selector_i,
    .fetch_enable_i,
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule
